// File: hdl/rtefi_pkg.sv
// rtefi packet engine shared types: bytes, ports, client slots and the per-beat structs
`default_nettype none

package rtefi_pkg;

	// one octet on the GMII-like stream
	typedef logic [7:0] byte_t;

	// UDP-style destination port, sent big-endian in the first two bytes
	typedef logic [15:0] udp_port_t;

	// client slot index
	// 0 is the echo client, 1 is the accumulator
	typedef logic [0:0] slot_t;

	// header bytes ahead of the payload, i.e. the port number
	localparam int hdr_len = 2;

	// one registered input byte with its framing flags
	typedef struct packed {
		byte_t data;   // frame byte
		logic  dv;     // byte valid
		logic  first;  // first byte of a frame
		logic  pay;    // byte sits past the header
	} rx_beat_t;

	// routing decision, one per frame
	typedef struct packed {
		logic  hit;    // frame goes out again
		slot_t slot;   // which client fills the payload
	} route_t;

	// what the scanner hands to each client
	typedef struct packed {
		byte_t idata;  // current input byte
		logic  raw_s;  // payload byte strobe for this client
		logic  raw_l;  // first payload byte of the frame
	} client_in_t;

endpackage

`default_nettype wire

// File: hdl/rtefi_port_table.sv
// two-entry UDP port table with byte-wide config writes and a priority match compare
`timescale 1ns/1ps
`default_nettype none

module rtefi_port_table #(
	parameter rtefi_pkg::udp_port_t udp_port0 = 7,
	parameter rtefi_pkg::udp_port_t udp_port1 = 801
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 config_p,
	input  logic [1:0]           config_a,
	input  rtefi_pkg::byte_t     config_d,
	input  rtefi_pkg::udp_port_t port,
	output logic                 match,
	output rtefi_pkg::slot_t     match_slot
);

	// table entries, indexed by slot
	rtefi_pkg::udp_port_t entry [2];

	// per-entry compare results
	logic hit0;
	logic hit1;

	// config_a[1] picks the slot, config_a[0] picks high or low byte
	always_ff @(posedge clk) begin
		if (reset) begin
			entry[0] <= udp_port0;
			entry[1] <= udp_port1;
		end else if (config_p) begin
			if (config_a[0]) begin
				entry[config_a[1]][15:8] <= config_d;
			end else begin
				entry[config_a[1]][7:0] <= config_d;
			end
		end
	end

	// compare runs all the time, the scanner samples it on the third byte
	always_comb begin
		hit0 = (port == entry[0]);
		hit1 = (port == entry[1]);
	end

	// slot 0 wins when both entries carry the same port
	always_comb begin
		match = hit0 || hit1;
		if (hit0) begin
			match_slot = 1'b0;
		end else begin
			match_slot = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rtefi_scanner.sv
// frame scanner: registers input beats, collects the port, issues routes and client strobes
`timescale 1ns/1ps
`default_nettype none

module rtefi_scanner (
	input  logic                  clk,
	input  logic                  reset,
	input  rtefi_pkg::byte_t      rxd,
	input  logic                  rx_dv,
	input  logic                  match,
	input  rtefi_pkg::slot_t      match_slot,
	output rtefi_pkg::udp_port_t  port,
	output rtefi_pkg::rx_beat_t   beat,
	output rtefi_pkg::route_t     route,
	output logic                  route_push,
	output rtefi_pkg::client_in_t cin0,
	output rtefi_pkg::client_in_t cin1
);

	// counter only has to reach the end of the header, then it sticks
	localparam int cnt_w = $clog2(rtefi_pkg::hdr_len + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_header,
		st_payload,
		st_drain
	} state_t;

	state_t state;

	// offset of the byte now on rxd, saturates at hdr_len
	logic [cnt_w-1:0] cnt;

	// decode of the byte currently on rxd
	logic pay_now;
	logic hit_now;
	logic take;
	logic first_pay;
	rtefi_pkg::slot_t slot_now;

	always_comb begin
		pay_now = rx_dv && (cnt == rtefi_pkg::hdr_len);
		// third byte: match comes straight from the table
		// later bytes: only the payload state forwards
		hit_now = (state == st_header && match) || state == st_payload;
		if (state == st_header) begin
			slot_now = match_slot;
		end else begin
			slot_now = route.slot;
		end
		take = pay_now && hit_now;
		first_pay = take && state == st_header;
	end

	// client inputs stay combinational so the client pipe lines up with the beat delay
	always_comb begin
		cin0.idata = rxd;
		cin0.raw_s = take && slot_now == 1'b0;
		cin0.raw_l = first_pay && slot_now == 1'b0;
		cin1.idata = rxd;
		cin1.raw_s = take && slot_now == 1'b1;
		cin1.raw_l = first_pay && slot_now == 1'b1;
	end

	// port number is big-endian, high byte arrives first
	always_ff @(posedge clk) begin
		if (rx_dv && state == st_idle) begin
			port[15:8] <= rxd;
		end
		if (rx_dv && state == st_header && cnt == 1) begin
			port[7:0] <= rxd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			beat <= '0;
			route <= '0;
			route_push <= 1'b0;
		end else begin
			// every byte goes into the beat register, valid or not
			beat.data <= rxd;
			beat.dv <= rx_dv;
			beat.first <= rx_dv && state == st_idle;
			beat.pay <= pay_now;
			route_push <= 1'b0;
			case (state)
				st_idle: begin
					if (rx_dv) begin
						state <= st_header;
						cnt <= 1;
					end
				end
				st_header: begin
					if (!rx_dv) begin
						// frame ended inside the header, drop it
						route_push <= 1'b1;
						route <= '0;
						state <= st_idle;
						cnt <= '0;
					end else if (cnt == rtefi_pkg::hdr_len) begin
						// third byte, port is complete
						route_push <= 1'b1;
						route.hit <= match;
						route.slot <= match ? match_slot : 1'b0;
						state <= match ? st_payload : st_drain;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_payload, st_drain: begin
					if (!rx_dv) begin
						state <= st_idle;
						cnt <= '0;
					end
				end
				default: begin
					state <= st_idle;
					cnt <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/rtefi_client_echo.sv
// echo client that hands each input byte back n_lat cycles later
`timescale 1ns/1ps
`default_nettype none

module rtefi_client_echo #(
	parameter int n_lat = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  rtefi_pkg::client_in_t cin,
	output rtefi_pkg::byte_t      odata
);

	// byte pipe, n_lat stages deep
	rtefi_pkg::byte_t dpipe [n_lat];

	// every byte moves through whether or not it was strobed
	always_ff @(posedge clk) begin
		dpipe[0] <= cin.idata;
		for (int i = 1; i < n_lat; i++) begin
			dpipe[i] <= dpipe[i-1];
		end
	end

	assign odata = dpipe[n_lat-1];

endmodule

`default_nettype wire

// File: hdl/rtefi_client_accum.sv
// accumulator client: returns the running payload byte sum mod 256, n_lat cycles later
`timescale 1ns/1ps
`default_nettype none

module rtefi_client_accum #(
	parameter int n_lat = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  rtefi_pkg::client_in_t cin,
	output rtefi_pkg::byte_t      odata
);

	// stage one, sum including the byte just presented
	rtefi_pkg::byte_t acc;

	// remaining n_lat-1 stages
	rtefi_pkg::byte_t pipe [n_lat-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (cin.raw_l) begin
			// new frame, restart from the first payload byte
			acc <= cin.idata;
		end else if (cin.raw_s) begin
			// wraps naturally at 8 bits
			acc <= acc + cin.idata;
		end
	end

	// pure delay, keeps the output aligned with the beat line
	always_ff @(posedge clk) begin
		pipe[0] <= acc;
		for (int i = 1; i < n_lat - 1; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	assign odata = pipe[n_lat-2];

endmodule

`default_nettype wire

// File: hdl/rtefi_tx_mux.sv
// tx mux: delays beats, queues per-frame routes and picks header or client bytes for output
`timescale 1ns/1ps
`default_nettype none

module rtefi_tx_mux #(
	parameter int n_lat = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  rtefi_pkg::rx_beat_t beat,
	input  rtefi_pkg::route_t   route,
	input  logic                route_push,
	input  rtefi_pkg::byte_t    odata0,
	input  rtefi_pkg::byte_t    odata1,
	output rtefi_pkg::byte_t    txd,
	output logic                tx_en
);

	// n_lat-1 delay stages here, the output register is the last one
	rtefi_pkg::rx_beat_t dly [n_lat-1];
	rtefi_pkg::rx_beat_t dbeat;

	// route queue, pointers carry one extra wrap bit
	rtefi_pkg::route_t q [4];
	logic [2:0] wr_ptr;
	logic [2:0] rd_ptr;
	logic empty;

	// route held for the frame now leaving
	rtefi_pkg::route_t route_q;
	rtefi_pkg::route_t head;
	rtefi_pkg::route_t cur;
	logic pop;

	always_ff @(posedge clk) begin
		dly[0] <= beat;
		for (int i = 1; i < n_lat - 1; i++) begin
			dly[i] <= dly[i-1];
		end
		// framing flags must not come up as junk after reset
		if (reset) begin
			for (int i = 0; i < n_lat - 1; i++) begin
				dly[i].dv <= 1'b0;
				dly[i].first <= 1'b0;
				dly[i].pay <= 1'b0;
			end
		end
	end

	always_comb begin
		dbeat = dly[n_lat-2];
		empty = (wr_ptr == rd_ptr);
		pop = dbeat.dv && dbeat.first;
		// with n_lat at 3 the route may arrive in the same cycle, take it directly
		head = empty ? route : q[rd_ptr[1:0]];
		cur = pop ? head : route_q;
	end

	always_ff @(posedge clk) begin
		if (route_push && !(pop && empty)) begin
			q[wr_ptr[1:0]] <= route;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			route_q <= '0;
		end else begin
			if (route_push && !(pop && empty)) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (pop) begin
				route_q <= head;
			end
		end
	end

	// header passes through, payload comes from the routed client
	always_ff @(posedge clk) begin
		if (dbeat.pay) begin
			txd <= cur.slot ? odata1 : odata0;
		end else begin
			txd <= dbeat.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_en <= 1'b0;
		end else begin
			tx_en <= dbeat.dv && cur.hit;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rtefi_blob.sv
// rtefi packet engine top: port table, scanner, echo and accumulator clients, tx mux
`timescale 1ns/1ps
`default_nettype none

module rtefi_blob #(
	parameter int n_lat = 4,  // client pipeline depth, 3 to 12
	parameter rtefi_pkg::udp_port_t udp_port0 = 7,
	parameter rtefi_pkg::udp_port_t udp_port1 = 801
) (
	input  logic             clk,
	input  logic             reset,
	// GMII-like receive side
	input  rtefi_pkg::byte_t rxd,
	input  logic             rx_dv,
	// port table writes
	input  logic             config_p,
	input  logic [1:0]       config_a,
	input  rtefi_pkg::byte_t config_d,
	// GMII-like transmit side
	output rtefi_pkg::byte_t txd,
	output logic             tx_en
);

	// scanner to table
	rtefi_pkg::udp_port_t port;
	logic match;
	rtefi_pkg::slot_t match_slot;

	// scanner to mux
	rtefi_pkg::rx_beat_t beat;
	rtefi_pkg::route_t route;
	logic route_push;

	// scanner to clients, and client results back
	rtefi_pkg::client_in_t cin0;
	rtefi_pkg::client_in_t cin1;
	rtefi_pkg::byte_t odata0;
	rtefi_pkg::byte_t odata1;

	rtefi_port_table #(
		.udp_port0(udp_port0),
		.udp_port1(udp_port1)
	) port_table_inst (
		.clk(clk),
		.reset(reset),
		.config_p(config_p),
		.config_a(config_a),
		.config_d(config_d),
		.port(port),
		.match(match),
		.match_slot(match_slot)
	);

	rtefi_scanner scanner_inst (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.rx_dv(rx_dv),
		.match(match),
		.match_slot(match_slot),
		.port(port),
		.beat(beat),
		.route(route),
		.route_push(route_push),
		.cin0(cin0),
		.cin1(cin1)
	);

	// slot 0
	rtefi_client_echo #(.n_lat(n_lat)) echo_inst (
		.clk(clk),
		.reset(reset),
		.cin(cin0),
		.odata(odata0)
	);

	// slot 1
	rtefi_client_accum #(.n_lat(n_lat)) accum_inst (
		.clk(clk),
		.reset(reset),
		.cin(cin1),
		.odata(odata1)
	);

	rtefi_tx_mux #(.n_lat(n_lat)) tx_mux_inst (
		.clk(clk),
		.reset(reset),
		.beat(beat),
		.route(route),
		.route_push(route_push),
		.odata0(odata0),
		.odata1(odata1),
		.txd(txd),
		.tx_en(tx_en)
	);

endmodule

`default_nettype wire

// File: dv/rtefi_blob_checker.sv
// rtefi scoreboard: reference model of the port table and clients, compares the txd stream
`timescale 1ns/1ps
`default_nettype none

module rtefi_blob_checker #(
	parameter int n_lat = 4,
	parameter rtefi_pkg::udp_port_t udp_port0 = 7,
	parameter rtefi_pkg::udp_port_t udp_port1 = 801
) (
	input  logic             clk,
	input  logic             reset,
	input  rtefi_pkg::byte_t rxd,
	input  logic             rx_dv,
	input  logic             config_p,
	input  logic [1:0]       config_a,
	input  rtefi_pkg::byte_t config_d,
	input  rtefi_pkg::byte_t txd,
	input  logic             tx_en,
	output int               mismatches,
	output int               missing,
	output int               unexpected,
	output int               forwarded,
	output int               dropped
);

	// one expected output byte, stamped with the cycle it must show up
	typedef struct packed {
		int               cyc;
		int               frame;
		int               idx;
		rtefi_pkg::byte_t data;
	} exp_t;

	// one byte seen with tx_en high
	typedef struct packed {
		int               cyc;
		rtefi_pkg::byte_t data;
	} obs_t;

	// model copy of the port table
	rtefi_pkg::udp_port_t tbl [2];

	// bytes of the frame now arriving
	rtefi_pkg::byte_t frame_q [$];
	exp_t exp_q [$];
	obs_t obs_q [$];

	logic in_frame;
	int start_cyc;
	int frame_id;
	int cyc = 0;

	// expected output of a frame that just ended
	task automatic build_expected();
		rtefi_pkg::udp_port_t port;
		rtefi_pkg::byte_t sum;
		exp_t e;
		logic hit;
		logic slot;
		hit = 1'b1;
		slot = 1'b0;
		sum = 8'h00;
		if (frame_q.size() <= rtefi_pkg::hdr_len) begin
			// too short to carry any payload
			dropped++;
			return;
		end
		port = {frame_q[0], frame_q[1]};
		// slot 0 first, so a duplicated port lands on the echo client
		if (port == tbl[0]) begin
			slot = 1'b0;
		end else if (port == tbl[1]) begin
			slot = 1'b1;
		end else begin
			hit = 1'b0;
		end
		if (!hit) begin
			dropped++;
			return;
		end
		for (int i = 0; i < frame_q.size(); i++) begin
			// input sampled at edge k shows up at sample k+n_lat+1
			e.cyc = start_cyc + i + n_lat + 1;
			e.frame = frame_id;
			e.idx = i;
			if (i < rtefi_pkg::hdr_len || !slot) begin
				e.data = frame_q[i];
			end else begin
				// running sum wraps at 8 bits
				sum = sum + frame_q[i];
				e.data = sum;
			end
			exp_q.push_back(e);
		end
		forwarded++;
	endtask

	// pair up observed and expected bytes whose cycle has already passed
	task automatic reconcile();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			if (obs_q.size() != 0 && (exp_q.size() == 0 || obs_q[0].cyc < exp_q[0].cyc)) begin
				unexpected++;
				$display("error at %0t: tx_en high at cycle %0d with no frame expected",
					$time, obs_q[0].cyc);
				void'(obs_q.pop_front());
			end else if (exp_q.size() != 0 && exp_q[0].cyc <= cyc &&
					(obs_q.size() == 0 || exp_q[0].cyc < obs_q[0].cyc)) begin
				missing++;
				$display("error at %0t: frame %0d byte %0d never appeared on txd at cycle %0d",
					$time, exp_q[0].frame, exp_q[0].idx, exp_q[0].cyc);
				void'(exp_q.pop_front());
			end else if (obs_q.size() != 0 && exp_q.size() != 0 &&
					obs_q[0].cyc == exp_q[0].cyc) begin
				if (obs_q[0].data !== exp_q[0].data) begin
					mismatches++;
					$display("Mismatch at %0t: frame %0d byte %0d txd 0x%02h expected 0x%02h",
						$time, exp_q[0].frame, exp_q[0].idx, obs_q[0].data, exp_q[0].data);
				end
				void'(obs_q.pop_front());
				void'(exp_q.pop_front());
			end else begin
				busy = 1'b0;
			end
		end
	endtask

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (reset) begin
			tbl[0] = udp_port0;
			tbl[1] = udp_port1;
			in_frame = 1'b0;
			frame_id = 0;
			mismatches = 0;
			missing = 0;
			unexpected = 0;
			forwarded = 0;
			dropped = 0;
			frame_q.delete();
			exp_q.delete();
			obs_q.delete();
		end else begin
			// table writes, one byte at a time
			if (config_p) begin
				if (config_a[0]) begin
					tbl[config_a[1]][15:8] = config_d;
				end else begin
					tbl[config_a[1]][7:0] = config_d;
				end
			end
			if (rx_dv) begin
				if (!in_frame) begin
					in_frame = 1'b1;
					start_cyc = cyc;
					frame_id++;
					frame_q.delete();
				end
				frame_q.push_back(rxd);
			end else if (in_frame) begin
				in_frame = 1'b0;
				build_expected();
			end
			if (tx_en) begin
				obs_q.push_back('{cyc: cyc, data: txd});
			end
			// all expected frames are known only between input frames
			if (!in_frame) begin
				reconcile();
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/rtefi_blob_tb.sv
// rtefi packet engine testbench driving random frames and port table writes into the DUT
`timescale 1ns/1ps
`default_nettype none

module rtefi_blob_tb;

	localparam int n_lat = 4;
	localparam rtefi_pkg::udp_port_t udp_port0 = 16'd7;
	localparam rtefi_pkg::udp_port_t udp_port1 = 16'd801;
	localparam int n_frames = 60;
	// about twice the mean cost of a frame with its gap and the odd table write
	localparam int cycle_limit = n_frames * 30;

	logic clk;
	logic reset;
	rtefi_pkg::byte_t rxd;
	logic rx_dv;
	logic config_p;
	logic [1:0] config_a;
	rtefi_pkg::byte_t config_d;
	rtefi_pkg::byte_t txd;
	logic tx_en;

	// counts from the checker
	int mismatches;
	int missing;
	int unexpected;
	int forwarded;
	int dropped;

	// stimulus view of the table to aim frames at live ports
	rtefi_pkg::udp_port_t tbl [2];
	// a port that was overwritten and should now be dropped
	rtefi_pkg::udp_port_t old_port;
	logic [31:0] lcg_state;
	int cycles = 0;

	rtefi_blob #(
		.n_lat(n_lat),
		.udp_port0(udp_port0),
		.udp_port1(udp_port1)
	) rtefi_blob_inst (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.rx_dv(rx_dv),
		.config_p(config_p),
		.config_a(config_a),
		.config_d(config_d),
		.txd(txd),
		.tx_en(tx_en)
	);

	rtefi_blob_checker #(
		.n_lat(n_lat),
		.udp_port0(udp_port0),
		.udp_port1(udp_port1)
	) checker_inst (
		.clk(clk),
		.reset(reset),
		.rxd(rxd),
		.rx_dv(rx_dv),
		.config_p(config_p),
		.config_a(config_a),
		.config_d(config_d),
		.txd(txd),
		.tx_en(tx_en),
		.mismatches(mismatches),
		.missing(missing),
		.unexpected(unexpected),
		.forwarded(forwarded),
		.dropped(dropped)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// LCG step with the Numerical Recipes constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// value in 0 .. n-1 from the upper bits
	function automatic int rand_range(int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:16]) % n;
	endfunction

	task automatic idle(int n);
		logic [31:0] r;
		repeat (n) begin
			r = lcg_next();
			@(posedge clk);
			rx_dv <= 1'b0;
			// junk on rxd that the DUT must ignore
			rxd <= r[23:16];
		end
	endtask

	// port number big-endian in the first two bytes
	task automatic send_frame(int len, rtefi_pkg::udp_port_t port);
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			r = lcg_next();
			@(posedge clk);
			rx_dv <= 1'b1;
			if (i == 0) begin
				rxd <= port[15:8];
			end else if (i == 1) begin
				rxd <= port[7:0];
			end else begin
				rxd <= r[23:16];
			end
		end
	endtask

	task automatic write_byte(logic [1:0] addr, rtefi_pkg::byte_t data);
		@(posedge clk);
		config_p <= 1'b1;
		config_a <= addr;
		config_d <= data;
	endtask

	// new port for a random slot and sometimes a copy of the other slot
	task automatic rewrite_slot();
		logic s;
		logic [31:0] r;
		rtefi_pkg::udp_port_t value;
		s = (rand_range(2) == 1);
		r = lcg_next();
		if (rand_range(4) == 0) begin
			value = tbl[!s];
		end else begin
			value = r[31:16];
		end
		// let the pipeline empty before touching the table
		idle(n_lat + 2);
		write_byte({s, 1'b1}, value[15:8]);
		write_byte({s, 1'b0}, value[7:0]);
		@(posedge clk);
		config_p <= 1'b0;
		old_port = tbl[s];
		tbl[s] = value;
	endtask

	initial begin : stimulus
		int len;
		int total;
		rtefi_pkg::udp_port_t port;
		logic [31:0] r;
		lcg_state = 32'd85;
		tbl[0] = udp_port0;
		tbl[1] = udp_port1;
		old_port = 16'd1234;
		reset = 1'b1;
		rxd = 8'h00;
		rx_dv = 1'b0;
		config_p = 1'b0;
		config_a = 2'b00;
		config_d = 8'h00;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int f = 0; f < n_frames; f++) begin
			if (rand_range(8) == 0) begin
				rewrite_slot();
			end
			len = 1 + rand_range(20);
			r = lcg_next();
			case (rand_range(6))
				0, 1: port = tbl[0];
				2, 3: port = tbl[1];
				4: port = old_port;
				default: port = r[31:16];
			endcase
			send_frame(len, port);
			// one idle cycle gives back to back frames still in flight
			idle(1 + rand_range(4));
		end
		// drain the DUT pipeline
		idle(n_lat + 8);
		// checker counts move on the rising edge, read them half a cycle later
		@(negedge clk);
		total = mismatches + missing + unexpected;
		$display("errors %0d (mismatch %0d, missing %0d, unexpected %0d) fwd %0d drop %0d",
			total, mismatches, missing, unexpected, forwarded, dropped);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: rtefi_blob.f
hdl/rtefi_pkg.sv
hdl/rtefi_port_table.sv
hdl/rtefi_scanner.sv
hdl/rtefi_client_echo.sv
hdl/rtefi_client_accum.sv
hdl/rtefi_tx_mux.sv
hdl/rtefi_blob.sv
dv/rtefi_blob_checker.sv
dv/rtefi_blob_tb.sv

// File: Makefile
# Verilator build and run for the rtefi packet engine testbench

obj_dir/Vrtefi_blob_tb: rtefi_blob.f $(wildcard hdl/*.sv) $(wildcard dv/*.sv)
	verilator --binary -j 0 --top-module rtefi_blob_tb -f rtefi_blob.f

run: obj_dir/Vrtefi_blob_tb
	./obj_dir/Vrtefi_blob_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
